//--- src.f
design/cfg_pkg.sv
design/cfg_regs.sv
design/cmd_queue.sv
design/cmd_executor.sv
design/cfg_top.sv
dv/cfg_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the configuration mailbox testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

if ! command -v verilator > /dev/null 2>&1; then
    echo "verilator is not on the PATH"
    exit 1
fi

rm -rf "${BUILD_DIR}" "${LOG_FILE}"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module cfg_tb -Mdir "${BUILD_DIR}" -o cfg_sim
build_status=$?
if [ ${build_status} -ne 0 ]; then
    echo "Verilator build stopped with status ${build_status}"
    exit 1
fi

"./${BUILD_DIR}/cfg_sim" > "${LOG_FILE}" 2>&1
sim_status=$?
cat "${LOG_FILE}"

if grep -q "Test failed" "${LOG_FILE}"; then
    exit 1
fi
if [ ${sim_status} -ne 0 ]; then
    echo "Simulation exited with status ${sim_status}"
    exit 1
fi
if ! grep -q "Test passed" "${LOG_FILE}"; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

//--- dv/cfg_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cfg_tb
    import cfg_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 40 * (QUEUE_DEPTH + 1) * (EXEC_CYCLES + 2) + 2000;
    localparam int POLL_BUDGET = (QUEUE_DEPTH + 1) * (EXEC_CYCLES + 2) + 10;
    localparam logic [6:0] OP_BAD = 7'h55; // Not a defined operation

    logic        clk;
    logic        arst_n;
    reg_req_t    bus_req;
    reg_data_t   bus_rdata;
    logic        irq;
    logic [31:0] lfsr_state = 32'hc27156fc;
    int          cycle_count = 0;

    // Reference model state
    logic        m_unlocked;
    logic [1:0]  m_key_cnt;
    logic        m_lock_seen;
    cfg_word_t   m_arg0;
    cfg_word_t   m_arg1;
    cfg_opcode_t m_last_op;
    logic        m_error;
    logic        m_irq;
    logic        m_overflow;
    int          m_outstanding;
    cfg_cmd_t    m_pending [$]; // Accepted, result not yet applied

    cfg_top DUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .bus_req   (bus_req),
        .bus_rdata (bus_rdata),
        .irq       (irq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("Test failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32 + x^22 + x^2 + x + 1
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic cfg_opcode_t random_opcode();
        logic [1:0] pick;
        pick = 2'(random_bits(2));
        if (pick == 2'd0) return {1'b0, OP_ADD};
        else if (pick == 2'd1) return {1'b0, OP_SWAP};
        else if (pick == 2'd2) return {1'b0, OP_XOR};
        else return {1'b0, OP_BAD};
    endfunction

    function automatic reg_addr_t reg_addr(input reg_index_e idx);
        return {1'b1, 11'd0, idx, 1'b0}; // Window at bit 16, word aligned
    endfunction

    function automatic cfg_result_t expect_result(input cfg_cmd_t c);
        cfg_result_t r;
        r.irq   = c.opcode[7];
        r.error = 1'b0;
        r.data0 = '0;
        r.data1 = '0;
        if (c.opcode[6:0] == OP_ADD) begin
            r.data0 = c.arg0 + c.arg1;
            r.data1 = {31'd0, r.data0 < c.arg0}; // Wrapped sum means a carry
        end else if (c.opcode[6:0] == OP_SWAP) begin
            r.data0 = c.arg1;
            r.data1 = c.arg0;
        end else if (c.opcode[6:0] == OP_XOR) begin
            r.data0 = c.arg0 ^ c.arg1;
            r.data1 = ~r.data0;
        end else begin
            r.error = 1'b1;
        end
        return r;
    endfunction

    function automatic reg_data_t model_read(input reg_index_e idx);
        case (idx)
            STATUS:    return {m_outstanding != 0, m_error, m_irq, m_unlocked, m_overflow, 11'd0};
            COMMAND:   return {8'd0, m_last_op};
            DATA_0_H:  return m_arg0[31:16];
            DATA_0_L:  return m_arg0[15:0];
            DATA_1_H:  return m_arg1[31:16];
            DATA_1_L:  return m_arg1[15:0];
            VERSION_H: return CFG_VERSION[31:16];
            VERSION_L: return CFG_VERSION[15:0];
            default:   return '0;
        endcase
    endfunction

    function automatic void model_write(input reg_index_e idx, input reg_data_t data);
        cfg_cmd_t c;
        if (!m_unlocked) begin
            if (idx == KEY_H || idx == KEY_L) begin
                if (data == UNLOCK_KEY[m_key_cnt]) begin
                    m_unlocked  = (m_key_cnt == 2'd3);
                    m_lock_seen = 1'b0;
                    m_key_cnt   = m_key_cnt + 2'd1;
                end else begin
                    m_key_cnt = 2'd0;
                end
            end
            return; // Everything else ignored while locked
        end
        case (idx)
            STATUS: begin
                m_irq      = 1'b0;
                m_overflow = 1'b0;
            end
            COMMAND: begin
                if (m_outstanding == QUEUE_DEPTH + 1) begin
                    m_overflow = 1'b1;
                end else begin
                    c.opcode  = data[7:0];
                    c.arg0    = m_arg0;
                    c.arg1    = m_arg1;
                    m_last_op = data[7:0];
                    m_error   = 1'b0;
                    m_pending.push_back(c);
                    m_outstanding++;
                end
            end
            DATA_0_H: m_arg0[31:16] = data;
            DATA_0_L: m_arg0[15:0]  = data;
            DATA_1_H: m_arg1[31:16] = data;
            DATA_1_L: m_arg1[15:0]  = data;
            KEY_H, KEY_L: begin
                if (data == LOCK_WORD) begin
                    if (m_lock_seen) m_unlocked = 1'b0;
                    m_lock_seen = !m_lock_seen;
                end else begin
                    m_lock_seen = 1'b0;
                end
            end
            default: ;
        endcase
    endfunction

    // Results land in command order
    function automatic void model_complete();
        cfg_result_t r;
        while (m_pending.size() > 0) begin
            r = expect_result(m_pending.pop_front());
            m_arg0  = r.data0;
            m_arg1  = r.data1;
            m_error = r.error;
            m_irq   = m_irq | r.irq;
            m_outstanding--;
        end
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // Bus tasks start and end on a falling edge
    task automatic write_reg(input reg_index_e idx, input reg_data_t data);
        bus_req.write = 1'b1;
        bus_req.read  = 1'b0;
        bus_req.addr  = reg_addr(idx);
        bus_req.wdata = data;
        model_write(idx, data);
        @(negedge clk);
        bus_req = '0;
    endtask

    task automatic read_reg(input reg_index_e idx, output reg_data_t data);
        bus_req.write = 1'b0;
        bus_req.read  = 1'b1;
        bus_req.addr  = reg_addr(idx);
        bus_req.wdata = '0;
        #5;
        data = bus_rdata;
        @(negedge clk);
        bus_req = '0;
    endtask

    task automatic check_reg(input reg_index_e idx);
        reg_data_t got;
        read_reg(idx, got);
        check_value(idx.name(), {16'd0, got}, {16'd0, model_read(idx)});
    endtask

    task automatic check_regs();
        for (int i = 0; i <= 5; i++) begin
            check_reg(reg_index_e'(i)); // STATUS through DATA_1_L
        end
        check_value("irq", {31'd0, irq}, {31'd0, m_irq});
    endtask

    task automatic check_status_bit(input int bit_pos, input logic exp, input string name);
        reg_data_t status;
        read_reg(STATUS, status);
        check_value(name, {31'd0, status[bit_pos]}, {31'd0, exp});
    endtask

    task automatic poll_idle();
        reg_data_t status;
        int tries;
        tries  = 0;
        status = 16'h8000;
        while (status[15] && tries < POLL_BUDGET) begin
            read_reg(STATUS, status);
            tries++;
        end
        assert (!status[15]) else begin
            $display("STATUS pending still set after %0d reads", POLL_BUDGET);
            $display("Test failed");
            $fatal(1);
        end
        model_complete();
    endtask

    task automatic load_args(input cfg_word_t a0, input cfg_word_t a1);
        write_reg(DATA_0_H, a0[31:16]);
        write_reg(DATA_0_L, a0[15:0]);
        write_reg(DATA_1_H, a1[31:16]);
        write_reg(DATA_1_L, a1[15:0]);
    endtask

    task automatic run_command(input cfg_opcode_t op);
        load_args(random_bits(32), random_bits(32));
        write_reg(COMMAND, {8'd0, op});
        poll_idle();
        check_regs();
    endtask

    initial begin
        reg_index_e idx;
        int         pos;
        reg_data_t  word;
        arst_n        = 1'b0;
        bus_req       = '0;
        m_unlocked    = 1'b0;
        m_key_cnt     = 2'd0;
        m_lock_seen   = 1'b0;
        m_arg0        = '0;
        m_arg1        = '0;
        m_last_op     = '0;
        m_error       = 1'b0;
        m_irq         = 1'b0;
        m_overflow    = 1'b0;
        m_outstanding = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);

        // Locked after reset
        check_regs();
        check_reg(VERSION_H);
        check_reg(VERSION_L);
        check_reg(KEY_H);
        for (int i = 0; i < 12; i++) begin
            idx = reg_index_e'(4'd1 + 4'(random_bits(3) % 5)); // COMMAND or DATA
            write_reg(idx, 16'(random_bits(16)));
        end
        check_regs();

        // Wrong word somewhere inside the key
        pos = 1 + int'(random_bits(2) % 3);
        for (int i = 0; i < 4; i++) begin
            if (i == pos) begin
                word = 16'(random_bits(16));
                if (word == UNLOCK_KEY[i]) begin
                    word = ~word;
                end
                write_reg(KEY_L, word);
            end
            write_reg((i % 2 == 0) ? KEY_H : KEY_L, UNLOCK_KEY[i]);
        end
        check_status_bit(12, 1'b0, "STATUS.unlocked");
        for (int i = 0; i < 4; i++) begin
            write_reg((i % 2 == 0) ? KEY_H : KEY_L, UNLOCK_KEY[i]);
        end
        check_status_bit(12, 1'b1, "STATUS.unlocked");
        check_regs();

        repeat (20) run_command(random_opcode());

        // Interrupt request and clear
        run_command({1'b1, OP_XOR});
        check_value("irq", {31'd0, irq}, 32'd1);
        check_status_bit(13, 1'b1, "STATUS.irq");
        write_reg(STATUS, 16'(random_bits(16)));
        check_regs();
        check_value("irq", {31'd0, irq}, 32'd0);

        // Six commands back to back, the last one overflows
        load_args(random_bits(32), random_bits(32));
        for (int i = 0; i < 6; i++) begin
            write_reg(COMMAND, {8'd0, random_opcode()});
        end
        poll_idle();
        check_regs();
        check_status_bit(11, 1'b1, "STATUS.overflow");

        // Relock
        write_reg(KEY_H, LOCK_WORD);
        write_reg(KEY_L, LOCK_WORD);
        write_reg(DATA_0_L, 16'(random_bits(16)));
        check_status_bit(12, 1'b0, "STATUS.unlocked");
        check_regs();

        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/cfg_top.sv
`timescale 1ns/10ps
`default_nettype none

module cfg_top
    import cfg_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire reg_req_t bus_req,
    output reg_data_t     bus_rdata,
    output logic          irq
);

    logic        cmd_push;
    cfg_cmd_t    cmd;
    cfg_cmd_t    head_cmd;
    logic        not_empty;
    logic        pop;
    logic        res_valid;
    cfg_result_t res;

    cfg_regs u_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .bus_req   (bus_req),
        .bus_rdata (bus_rdata),
        .cmd_push  (cmd_push),
        .cmd       (cmd),
        .res_valid (res_valid),
        .res       (res),
        .irq       (irq)
    );

    cmd_queue u_queue (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (cmd_push),
        .push_cmd  (cmd),
        .pop       (pop),
        .head_cmd  (head_cmd),
        .not_empty (not_empty)
    );

    cmd_executor u_exec (
        .clk       (clk),
        .arst_n    (arst_n),
        .not_empty (not_empty),
        .head_cmd  (head_cmd),
        .pop       (pop),
        .res_valid (res_valid),
        .res       (res)
    );

endmodule

`default_nettype wire

//--- design/cmd_executor.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_executor
    import cfg_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire logic     not_empty,
    input  wire cfg_cmd_t head_cmd,
    output logic          pop,
    output logic          res_valid,
    output cfg_result_t   res
);

    typedef enum logic {
        IDLE,
        RUN
    } state_e;

    state_e             state;
    logic [EXEC_CW-1:0] cyc_cnt;
    cfg_cmd_t           cur_cmd;
    logic               carry;
    cfg_word_t          sum;

    assign pop       = (state == IDLE) && not_empty;
    assign res_valid = (state == RUN) && (cyc_cnt == EXEC_CW'(EXEC_CYCLES - 1));
    assign {carry, sum} = {1'b0, cur_cmd.arg0} + {1'b0, cur_cmd.arg1};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            cyc_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (pop) begin
                        state   <= RUN;
                        cyc_cnt <= '0;
                    end
                end
                RUN: begin
                    cyc_cnt <= cyc_cnt + 1'b1;
                    if (res_valid) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            cur_cmd <= head_cmd;
        end
    end

    always_comb begin
        res.error = 1'b0;
        res.irq   = cur_cmd.opcode[7];
        res.data0 = '0;
        res.data1 = '0;
        case (cur_cmd.opcode[6:0])
            OP_ADD: begin
                res.data0 = sum;
                res.data1 = {31'd0, carry};
            end
            OP_SWAP: begin
                res.data0 = cur_cmd.arg1;
                res.data1 = cur_cmd.arg0;
            end
            OP_XOR: begin
                res.data0 = cur_cmd.arg0 ^ cur_cmd.arg1;
                res.data1 = ~(cur_cmd.arg0 ^ cur_cmd.arg1);
            end
            default: res.error = 1'b1; // Unknown opcode
        endcase
    end

    // Each pop comes from IDLE and yields exactly one result later
    a_pop_idle_result: assert property (
        @(posedge clk) disable iff (!arst_n)
        pop |-> (state == IDLE) ##EXEC_CYCLES res_valid
    );

endmodule

`default_nettype wire

//--- design/cmd_queue.sv
`timescale 1ns/10ps
`default_nettype none

module cmd_queue
    import cfg_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     arst_n,
    input  wire logic     push,
    input  wire cfg_cmd_t push_cmd,
    input  wire logic     pop,
    output cfg_cmd_t      head_cmd,
    output logic          not_empty
);

    cfg_cmd_t            mem [QUEUE_DEPTH];
    logic [QUEUE_AW-1:0] wr_ptr;
    logic [QUEUE_AW-1:0] rd_ptr;
    logic [QUEUE_AW:0]   count;
    logic                full;

    assign head_cmd  = mem[rd_ptr];
    assign not_empty = (count != '0);
    assign full      = (count == (QUEUE_AW + 1)'(QUEUE_DEPTH));

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_cmd;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1; // Depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Upstream outstanding limit keeps the queue from overflowing
    a_no_push_full: assert property (
        @(posedge clk) disable iff (!arst_n) push |-> (!full || pop)
    );

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (!arst_n) pop |-> not_empty
    );

endmodule

`default_nettype wire

//--- design/cfg_regs.sv
`timescale 1ns/10ps
`default_nettype none

module cfg_regs
    import cfg_pkg::*;
(
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire reg_req_t    bus_req,
    output reg_data_t        bus_rdata,
    output logic             cmd_push,
    output cfg_cmd_t         cmd,
    input  wire logic        res_valid,
    input  wire cfg_result_t res,
    output logic             irq
);

    logic         in_window;
    logic         reg_wr;
    reg_index_e   idx;
    logic         unlocked;
    logic [1:0]   key_cnt;   // Position in unlock key
    logic         lock_seen; // One LOCK_WORD already written
    cfg_word_t    arg0;
    cfg_word_t    arg1;
    cfg_opcode_t  last_op;
    logic         error;
    logic         overflow;
    outstanding_t outstanding;
    logic         cmd_full;
    logic         cmd_accept;
    logic         pending;

    assign in_window = bus_req.addr[16] && (bus_req.addr[15:5] == 11'd0);
    assign idx       = reg_index_e'(bus_req.addr[4:1]);
    assign reg_wr    = bus_req.write && in_window;
    assign pending   = (outstanding != '0);
    assign cmd_full  = (outstanding == outstanding_t'(OUTSTANDING_MAX));
    assign cmd_accept = reg_wr && unlocked && (idx == COMMAND) && !cmd_full;

    always_comb begin
        bus_rdata = '0;
        if (bus_req.read && in_window) begin
            case (idx)
                STATUS:    bus_rdata = {pending, error, irq, unlocked, overflow, 11'd0};
                COMMAND:   bus_rdata = {8'd0, last_op};
                DATA_0_H:  bus_rdata = arg0[31:16];
                DATA_0_L:  bus_rdata = arg0[15:0];
                DATA_1_H:  bus_rdata = arg1[31:16];
                DATA_1_L:  bus_rdata = arg1[15:0];
                VERSION_H: bus_rdata = CFG_VERSION[31:16];
                VERSION_L: bus_rdata = CFG_VERSION[15:0];
                default:   bus_rdata = '0; // KEY and unused slots
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            unlocked    <= 1'b0;
            key_cnt     <= '0;
            lock_seen   <= 1'b0;
            arg0        <= '0;
            arg1        <= '0;
            last_op     <= '0;
            error       <= 1'b0;
            overflow    <= 1'b0;
            irq         <= 1'b0;
            cmd_push    <= 1'b0;
            outstanding <= '0;
        end else begin
            cmd_push <= cmd_accept;

            if (reg_wr && !unlocked && (idx == KEY_H || idx == KEY_L)) begin
                if (bus_req.wdata == UNLOCK_KEY[key_cnt]) begin
                    key_cnt <= key_cnt + 2'd1; // Wraps to 0 after the last word
                    if (key_cnt == 2'd3) begin
                        unlocked  <= 1'b1;
                        lock_seen <= 1'b0;
                    end
                end else begin
                    key_cnt <= '0;
                end
            end

            if (reg_wr && unlocked) begin
                case (idx)
                    STATUS: begin
                        irq      <= 1'b0;
                        overflow <= 1'b0;
                    end
                    COMMAND: begin
                        if (cmd_full) begin
                            overflow <= 1'b1; // Command dropped
                        end else begin
                            last_op <= bus_req.wdata[7:0];
                            error   <= 1'b0;
                        end
                    end
                    DATA_0_H: arg0[31:16] <= bus_req.wdata;
                    DATA_0_L: arg0[15:0]  <= bus_req.wdata;
                    DATA_1_H: arg1[31:16] <= bus_req.wdata;
                    DATA_1_L: arg1[15:0]  <= bus_req.wdata;
                    KEY_H, KEY_L: begin
                        if (bus_req.wdata == LOCK_WORD) begin
                            lock_seen <= !lock_seen;
                            if (lock_seen) begin
                                unlocked <= 1'b0;
                            end
                        end else begin
                            lock_seen <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end

            // Results take priority over a host write in the same cycle
            if (res_valid) begin
                arg0  <= res.data0;
                arg1  <= res.data1;
                error <= res.error;
                if (res.irq) begin
                    irq <= 1'b1;
                end
            end

            case ({cmd_accept, res_valid})
                2'b10:   outstanding <= outstanding + outstanding_t'(1);
                2'b01:   outstanding <= outstanding - outstanding_t'(1);
                default: outstanding <= outstanding;
            endcase
        end
    end

    // Arguments sampled at the COMMAND write edge
    always_ff @(posedge clk) begin
        if (cmd_accept) begin
            cmd.opcode <= bus_req.wdata[7:0];
            cmd.arg0   <= arg0;
            cmd.arg1   <= arg1;
        end
    end

    a_outstanding_max: assert property (
        @(posedge clk) disable iff (!arst_n)
        outstanding <= outstanding_t'(OUTSTANDING_MAX)
    );

endmodule

`default_nettype wire

//--- design/cfg_pkg.sv
`default_nettype none

package cfg_pkg;

    localparam int QUEUE_DEPTH = 4;
    localparam int EXEC_CYCLES = 4;
    localparam int QUEUE_AW = $clog2(QUEUE_DEPTH);
    localparam int EXEC_CW = $clog2(EXEC_CYCLES);
    localparam int OUTSTANDING_MAX = QUEUE_DEPTH + 1; // Queued plus one executing

    typedef logic [16:0] reg_addr_t;
    typedef logic [15:0] reg_data_t;
    typedef logic [31:0] cfg_word_t;
    typedef logic [7:0]  cfg_opcode_t;
    typedef logic [$clog2(OUTSTANDING_MAX + 1)-1:0] outstanding_t;

    typedef enum logic [3:0] {
        STATUS,
        COMMAND,
        DATA_0_H,
        DATA_0_L,
        DATA_1_H,
        DATA_1_L,
        VERSION_H,
        VERSION_L,
        KEY_H,
        KEY_L
    } reg_index_e;

    typedef struct packed {
        logic      write;
        logic      read;
        reg_addr_t addr;
        reg_data_t wdata;
    } reg_req_t;

    typedef struct packed {
        cfg_opcode_t opcode; // Bit 7 requests an interrupt
        cfg_word_t   arg0;
        cfg_word_t   arg1;
    } cfg_cmd_t;

    typedef struct packed {
        logic      error;
        logic      irq;
        cfg_word_t data0;
        cfg_word_t data1;
    } cfg_result_t;

    localparam logic [6:0] OP_ADD  = 7'd1;
    localparam logic [6:0] OP_SWAP = 7'd2;
    localparam logic [6:0] OP_XOR  = 7'd3;

    localparam reg_data_t UNLOCK_KEY [4] = '{16'h5F55, 16'h4E4C, 16'h4F43, 16'h4B5F};
    localparam reg_data_t LOCK_WORD = 16'hFFFF;
    localparam cfg_word_t CFG_VERSION = 32'h0001_0203;

endpackage

`default_nettype wire
